// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_router_front
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
hdl/noc_pkg.sv
hdl/flit_if.sv
hdl/port_dispatch.sv
hdl/route_comp.sv
hdl/worm_arbiter.sv
hdl/router_front_top.sv
verif/tb_router_front.sv

// ==== hdl/flit_if.sv ====
`default_nettype none

// one flit stream, valid/ready handshake
interface flit_if;

    logic                        valid;
    logic                        ready;
    noc_pkg::flit_t              flit;
    // arrival port, or output direction after routing
    logic [noc_pkg::dir_w-1:0]   dir_in;

    modport src (
        output valid,
        output flit,
        output dir_in,
        input  ready
    );

    modport dst (
        input  valid,
        input  flit,
        input  dir_in,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

    ////////////////////
    // flit layout
    ////////////////////
    localparam int flit_w    = 32;
    localparam int type_w    = 3;
    localparam int coord_w   = 2;
    localparam int cmp_w     = 4;
    localparam int dir_w     = 3;
    localparam int lane_w    = 3;
    localparam int payload_w = flit_w - type_w - 1 - 3 * coord_w - cmp_w;

    // torus extent, 4x4x4
    localparam int x_size = 4;
    localparam int y_size = 4;
    localparam int z_size = 4;

    // flit types, single is head and tail at once
    localparam logic [type_w-1:0] head_flit   = 3'd0;
    localparam logic [type_w-1:0] body_flit   = 3'd1;
    localparam logic [type_w-1:0] tail_flit   = 3'd2;
    localparam logic [type_w-1:0] single_flit = 3'd3;

    ////////////////////
    // direction codes
    ////////////////////
    localparam logic [dir_w-1:0] dir_inject = 3'd0;
    localparam logic [dir_w-1:0] dir_xpos   = 3'd1;
    localparam logic [dir_w-1:0] dir_ypos   = 3'd2;
    localparam logic [dir_w-1:0] dir_zpos   = 3'd3;
    localparam logic [dir_w-1:0] dir_xneg   = 3'd4;
    localparam logic [dir_w-1:0] dir_yneg   = 3'd5;
    localparam logic [dir_w-1:0] dir_zneg   = 3'd6;
    localparam logic [dir_w-1:0] dir_eject  = 3'd7;

    // inject lane plus six torus links
    localparam int num_lanes = 7;

    // body and tail flits only interpret ftype
    typedef struct packed {
        logic [type_w-1:0]    ftype;
        logic                 vc_class;
        logic [coord_w-1:0]   dst_z;
        logic [coord_w-1:0]   dst_y;
        logic [coord_w-1:0]   dst_x;
        logic [cmp_w-1:0]     cmp;
        logic [payload_w-1:0] payload;
    } flit_t;

endpackage

`default_nettype wire

// ==== hdl/port_dispatch.sv ====
`default_nettype none

module port_dispatch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  noc_pkg::flit_t               in_flit,
    input  logic [noc_pkg::lane_w-1:0]   in_port,
    flit_if.src                          lanes [noc_pkg::num_lanes]
);

    logic                          full_q;
    noc_pkg::flit_t                flit_q;
    logic [noc_pkg::lane_w-1:0]    port_q;
    logic [noc_pkg::num_lanes-1:0] sel_ready;
    logic                          drain;
    logic                          accept;

    ////////////////////
    // lane steering
    ////////////////////
    genvar i;
    generate
        for (i = 0; i < noc_pkg::num_lanes; i++) begin : g_lane
            assign lanes[i].valid  = full_q && (port_q == (noc_pkg::lane_w)'(i));
            assign lanes[i].flit   = flit_q;
            assign lanes[i].dir_in = port_q;
            // only the addressed lane may drain the register
            assign sel_ready[i]    = (port_q == (noc_pkg::lane_w)'(i)) && lanes[i].ready;
        end
    endgenerate

    assign drain    = full_q && (|sel_ready);
    assign in_ready = !full_q || drain;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (drain) begin
            full_q <= 1'b0;
        end
    end

    // flit and its port are held together
    always_ff @(posedge clk) begin
        if (accept) begin
            flit_q <= in_flit;
            port_q <= in_port;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/route_comp.sv ====
`default_nettype none

module route_comp #(
    parameter int node_x = 0,
    parameter int node_y = 0,
    parameter int node_z = 0
) (
    input  logic clk,
    input  logic rst,
    flit_if.dst  up,
    flit_if.src  down
);

    logic                         full_q;
    noc_pkg::flit_t               flit_q;
    // output direction of the last flit, held for the worm
    logic [noc_pkg::dir_w-1:0]    dir_q;

    logic                         accept;
    logic                         is_head;
    logic                         in_worm;
    logic                         straight;
    logic                         crossing;
    logic [noc_pkg::dir_w-1:0]    route_dir;
    logic [noc_pkg::dir_w-1:0]    next_dir;
    noc_pkg::flit_t               next_flit;

    // shortest way around one ring, tie goes positive
    function automatic logic [noc_pkg::dir_w-1:0] dim_dir(
        input int                        dst,
        input int                        node,
        input int                        size,
        input logic [noc_pkg::dir_w-1:0] pos,
        input logic [noc_pkg::dir_w-1:0] neg
    );
        int fwd;
        fwd = (dst - node + size) % size;
        if (fwd <= size / 2) begin
            return pos;
        end
        return neg;
    endfunction

    ////////////////////
    // xyz routing
    ////////////////////
    always_comb begin
        if (int'(up.flit.dst_x) != node_x) begin
            route_dir = dim_dir(int'(up.flit.dst_x), node_x, noc_pkg::x_size,
                                noc_pkg::dir_xpos, noc_pkg::dir_xneg);
        end else if (int'(up.flit.dst_y) != node_y) begin
            route_dir = dim_dir(int'(up.flit.dst_y), node_y, noc_pkg::y_size,
                                noc_pkg::dir_ypos, noc_pkg::dir_yneg);
        end else if (int'(up.flit.dst_z) != node_z) begin
            route_dir = dim_dir(int'(up.flit.dst_z), node_z, noc_pkg::z_size,
                                noc_pkg::dir_zpos, noc_pkg::dir_zneg);
        end else begin
            route_dir = noc_pkg::dir_eject;
        end
    end

    assign is_head = (up.flit.ftype == noc_pkg::head_flit) ||
                     (up.flit.ftype == noc_pkg::single_flit);
    assign in_worm = (up.flit.ftype == noc_pkg::body_flit) ||
                     (up.flit.ftype == noc_pkg::tail_flit);

    // body and tail follow the head
    assign next_dir = in_worm ? dir_q : route_dir;

    ////////////////////
    // dateline
    ////////////////////
    always_comb begin
        case (next_dir)
            noc_pkg::dir_xpos: crossing = (node_x == noc_pkg::x_size - 1);
            noc_pkg::dir_ypos: crossing = (node_y == noc_pkg::y_size - 1);
            noc_pkg::dir_zpos: crossing = (node_z == noc_pkg::z_size - 1);
            noc_pkg::dir_xneg: crossing = (node_x == 0);
            noc_pkg::dir_yneg: crossing = (node_y == 0);
            noc_pkg::dir_zneg: crossing = (node_z == 0);
            default:           crossing = 1'b0;
        endcase
    end

    // dir_in carries the direction the flit was travelling on arrival
    assign straight = (next_dir == up.dir_in);

    always_comb begin
        next_flit = up.flit;
        if (is_head && (next_dir != noc_pkg::dir_eject)) begin
            if (!straight) begin
                // injection or a turn restarts in class 0
                next_flit.vc_class = 1'b0;
            end else if (crossing) begin
                next_flit.vc_class = 1'b1;
            end
        end
    end

    ////////////////////
    // stage register
    ////////////////////
    assign up.ready    = !full_q || down.ready;
    assign accept      = up.valid && up.ready;

    assign down.valid  = full_q;
    assign down.flit   = flit_q;
    assign down.dir_in = dir_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
            dir_q  <= noc_pkg::dir_inject;
        end else if (accept) begin
            full_q <= 1'b1;
            dir_q  <= next_dir;
        end else if (down.ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            flit_q <= next_flit;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/router_front_top.sv ====
`default_nettype none

module router_front_top #(
    parameter int node_x = 0,
    parameter int node_y = 0,
    parameter int node_z = 0
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         in_valid,
    output logic                         in_ready,
    input  noc_pkg::flit_t               in_flit,
    input  logic [noc_pkg::lane_w-1:0]   in_port,

    output logic                         out_valid,
    input  logic                         out_ready,
    output noc_pkg::flit_t               out_flit,
    output logic [noc_pkg::dir_w-1:0]    out_dir,

    output logic                         ej_valid,
    input  logic                         ej_ready,
    output noc_pkg::flit_t               ej_flit
);

    // dispatcher to route units
    flit_if lane_q [noc_pkg::num_lanes] ();
    // route units to arbiter
    flit_if routed [noc_pkg::num_lanes] ();

    port_dispatch port_dispatch_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_flit  (in_flit),
        .in_port  (in_port),
        .lanes    (lane_q)
    );

    ////////////////////
    // route units
    ////////////////////
    genvar i;
    generate
        for (i = 0; i < noc_pkg::num_lanes; i++) begin : g_route
            route_comp #(
                .node_x (node_x),
                .node_y (node_y),
                .node_z (node_z)
            ) route_comp_i (
                .clk  (clk),
                .rst  (rst),
                .up   (lane_q[i]),
                .down (routed[i])
            );
        end
    endgenerate

    worm_arbiter worm_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .lanes     (routed),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_flit  (out_flit),
        .out_dir   (out_dir),
        .ej_valid  (ej_valid),
        .ej_ready  (ej_ready),
        .ej_flit   (ej_flit)
    );

endmodule

`default_nettype wire

// ==== hdl/worm_arbiter.sv ====
`default_nettype none

module worm_arbiter (
    input  logic                         clk,
    input  logic                         rst,
    flit_if.dst                          lanes [noc_pkg::num_lanes],
    output logic                         out_valid,
    input  logic                         out_ready,
    output noc_pkg::flit_t               out_flit,
    output logic [noc_pkg::dir_w-1:0]    out_dir,
    output logic                         ej_valid,
    input  logic                         ej_ready,
    output noc_pkg::flit_t               ej_flit
);

    logic [noc_pkg::num_lanes-1:0] lane_valid;
    logic [noc_pkg::num_lanes-1:0] lane_ready;
    noc_pkg::flit_t                lane_flit [noc_pkg::num_lanes];
    logic [noc_pkg::dir_w-1:0]     lane_dir  [noc_pkg::num_lanes];

    // index 0 is the network output, index 1 the eject output
    logic [noc_pkg::num_lanes-1:0] req    [2];
    logic                          pop    [2];
    logic [noc_pkg::lane_w-1:0]    win    [2];
    logic                          oready [2];
    logic                          ovalid [2];
    noc_pkg::flit_t                oflit  [2];
    logic [noc_pkg::dir_w-1:0]     odir_q;

    ////////////////////
    // lane side
    ////////////////////
    genvar i;
    generate
        for (i = 0; i < noc_pkg::num_lanes; i++) begin : g_lane
            assign lane_valid[i] = lanes[i].valid;
            assign lane_flit[i]  = lanes[i].flit;
            assign lane_dir[i]   = lanes[i].dir_in;
            assign req[0][i]     = lane_valid[i] && (lane_dir[i] != noc_pkg::dir_eject);
            assign req[1][i]     = lane_valid[i] && (lane_dir[i] == noc_pkg::dir_eject);
            assign lane_ready[i] = (pop[0] && (win[0] == (noc_pkg::lane_w)'(i))) ||
                                   (pop[1] && (win[1] == (noc_pkg::lane_w)'(i)));
            assign lanes[i].ready = lane_ready[i];
        end
    endgenerate

    assign oready[0] = out_ready;
    assign oready[1] = ej_ready;

    ////////////////////
    // per output grant
    ////////////////////
    genvar o;
    generate
        for (o = 0; o < 2; o++) begin : g_out
            logic                       lock_q;
            logic [noc_pkg::lane_w-1:0] owner_q;
            logic [noc_pkg::lane_w-1:0] last_q;
            logic [noc_pkg::lane_w-1:0] pick;
            logic                       found;
            logic                       win_valid;
            logic                       free;
            logic                       last_flit;
            logic                       ovalid_q;
            noc_pkg::flit_t             oflit_q;

            // round robin from the lane after the last winner
            always_comb begin
                int idx;
                found = 1'b0;
                pick  = last_q;
                for (int k = 1; k <= noc_pkg::num_lanes; k++) begin
                    idx = (int'(last_q) + k) % noc_pkg::num_lanes;
                    if (!found && req[o][idx]) begin
                        found = 1'b1;
                        pick  = (noc_pkg::lane_w)'(idx);
                    end
                end
            end

            assign win[o]    = lock_q ? owner_q : pick;
            assign win_valid = lock_q ? req[o][owner_q] : found;
            assign free      = !ovalid_q || oready[o];
            assign pop[o]    = win_valid && free;
            assign last_flit = (lane_flit[win[o]].ftype == noc_pkg::tail_flit) ||
                               (lane_flit[win[o]].ftype == noc_pkg::single_flit);

            always_ff @(posedge clk) begin
                if (rst) begin
                    lock_q   <= 1'b0;
                    owner_q  <= '0;
                    last_q   <= '0;
                    ovalid_q <= 1'b0;
                end else if (pop[o]) begin
                    ovalid_q <= 1'b1;
                    // grant stays until the tail has gone
                    lock_q   <= !last_flit;
                    owner_q  <= win[o];
                    if (!lock_q) begin
                        last_q <= win[o];
                    end
                end else if (oready[o]) begin
                    ovalid_q <= 1'b0;
                end
            end

            always_ff @(posedge clk) begin
                if (pop[o]) begin
                    oflit_q <= lane_flit[win[o]];
                end
            end

            assign ovalid[o] = ovalid_q;
            assign oflit[o]  = oflit_q;
        end
    endgenerate

    // direction only matters on the network side
    always_ff @(posedge clk) begin
        if (pop[0]) begin
            odir_q <= lane_dir[win[0]];
        end
    end

    assign out_valid = ovalid[0];
    assign out_flit  = oflit[0];
    assign out_dir   = odir_q;
    assign ej_valid  = ovalid[1];
    assign ej_flit   = oflit[1];

endmodule

`default_nettype wire

// ==== verif/tb_router_front.sv ====
`default_nettype none

module tb_router_front;

    localparam int node_x   = 1;
    localparam int node_y   = 2;
    localparam int node_z   = 3;
    localparam int num_rows = 16;

    typedef struct packed {
        logic [noc_pkg::lane_w-1:0]  port;
        logic [noc_pkg::coord_w-1:0] dx;
        logic [noc_pkg::coord_w-1:0] dy;
        logic [noc_pkg::coord_w-1:0] dz;
        logic [3:0]                  nflits;
        logic                        vc_in;
        logic [noc_pkg::dir_w-1:0]   exp_dir;
        logic                        exp_vc;
    } row_t;

    // port, dst x y z, flits, class in, expected direction, expected class
    localparam row_t pkt_table [num_rows] = '{
        '{noc_pkg::dir_inject, 2'd2, 2'd2, 2'd3, 4'd1, 1'b1, noc_pkg::dir_xpos,  1'b0},
        '{noc_pkg::dir_inject, 2'd3, 2'd0, 2'd0, 4'd3, 1'b1, noc_pkg::dir_xpos,  1'b0},
        '{noc_pkg::dir_xpos,   2'd0, 2'd2, 2'd3, 4'd2, 1'b1, noc_pkg::dir_xneg,  1'b0},
        '{noc_pkg::dir_xpos,   2'd2, 2'd0, 2'd0, 4'd4, 1'b1, noc_pkg::dir_xpos,  1'b1},
        '{noc_pkg::dir_ypos,   2'd1, 2'd3, 2'd3, 4'd2, 1'b0, noc_pkg::dir_ypos,  1'b0},
        '{noc_pkg::dir_ypos,   2'd1, 2'd0, 2'd1, 4'd1, 1'b1, noc_pkg::dir_ypos,  1'b1},
        '{noc_pkg::dir_yneg,   2'd1, 2'd1, 2'd0, 4'd3, 1'b1, noc_pkg::dir_yneg,  1'b1},
        '{noc_pkg::dir_zpos,   2'd1, 2'd2, 2'd0, 4'd2, 1'b0, noc_pkg::dir_zpos,  1'b1},
        '{noc_pkg::dir_zpos,   2'd1, 2'd2, 2'd1, 4'd1, 1'b0, noc_pkg::dir_zpos,  1'b1},
        '{noc_pkg::dir_zneg,   2'd1, 2'd2, 2'd2, 4'd3, 1'b1, noc_pkg::dir_zneg,  1'b1},
        '{noc_pkg::dir_zneg,   2'd1, 2'd2, 2'd3, 4'd3, 1'b1, noc_pkg::dir_eject, 1'b1},
        '{noc_pkg::dir_xneg,   2'd1, 2'd2, 2'd3, 4'd2, 1'b0, noc_pkg::dir_eject, 1'b0},
        '{noc_pkg::dir_xneg,   2'd0, 2'd3, 2'd1, 4'd2, 1'b1, noc_pkg::dir_xneg,  1'b1},
        '{noc_pkg::dir_zpos,   2'd1, 2'd1, 2'd0, 4'd1, 1'b1, noc_pkg::dir_yneg,  1'b0},
        '{noc_pkg::dir_inject, 2'd1, 2'd2, 2'd3, 4'd1, 1'b1, noc_pkg::dir_eject, 1'b1},
        '{noc_pkg::dir_yneg,   2'd2, 2'd2, 2'd3, 4'd4, 1'b1, noc_pkg::dir_xpos,  1'b0}
    };

    function automatic int table_flits();
        int n;
        n = 0;
        for (int k = 0; k < num_rows; k++) begin
            n = n + int'(pkt_table[k].nflits);
        end
        return n;
    endfunction

    localparam int total_flits    = table_flits();
    localparam int timeout_cycles = 40 * total_flits + 200;

    logic                        clk;
    logic                        rst;
    logic                        in_valid;
    logic                        in_ready;
    noc_pkg::flit_t              in_flit;
    logic [noc_pkg::lane_w-1:0]  in_port;
    logic                        out_valid;
    logic                        out_ready = 1'b0;
    noc_pkg::flit_t              out_flit;
    logic [noc_pkg::dir_w-1:0]   out_dir;
    logic                        ej_valid;
    logic                        ej_ready = 1'b0;
    noc_pkg::flit_t              ej_flit;

    integer                      seed = 97334;
    logic                        random_ready = 1'b0;
    int                          cycle = 0;
    int                          in_cycle0 = 0;
    int                          out_cycle0 = 0;
    int                          rx_total = 0;
    int                          rx_count [num_rows];
    // row of the open worm on each output
    // -1 means no worm is open
    int                          open_row [2];
    logic                        out_stall = 1'b0;
    logic                        ej_stall = 1'b0;
    noc_pkg::flit_t              out_held;
    noc_pkg::flit_t              ej_held;
    logic [noc_pkg::dir_w-1:0]   dir_held;

    router_front_top #(
        .node_x (node_x),
        .node_y (node_y),
        .node_z (node_z)
    ) router_front_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_flit   (in_flit),
        .in_port   (in_port),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_flit  (out_flit),
        .out_dir   (out_dir),
        .ej_valid  (ej_valid),
        .ej_ready  (ej_ready),
        .ej_flit   (ej_flit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // reporting
    ////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                                $time, what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d flits received",
                                cycle, rx_total, total_flits));
        end
    end

    ////////////////////
    // reference model
    ////////////////////
    // returns {class, direction} for a head flit of this row
    function automatic logic [3:0] ref_route(input row_t r);
        int         dst [3];
        int         here [3];
        int         fwd;
        int         dim;
        logic       edge_node;
        logic [2:0] dir;
        logic       vc;
        dst[0]  = int'(r.dx);
        dst[1]  = int'(r.dy);
        dst[2]  = int'(r.dz);
        here[0] = node_x;
        here[1] = node_y;
        here[2] = node_z;
        dir     = noc_pkg::dir_eject;
        dim     = 0;
        for (int d = 0; d < 3; d++) begin
            if (dir == noc_pkg::dir_eject && dst[d] != here[d]) begin
                dim = d;
                fwd = dst[d] - here[d];
                if (fwd < 0) begin
                    fwd = fwd + 4;
                end
                // positive codes 1..3 and negative codes 4..6 follow x y z order
                dir = (2 * fwd <= 4) ? 3'(d + 1) : 3'(d + 4);
            end
        end
        if (dir <= noc_pkg::dir_zpos) begin
            edge_node = (here[dim] == 3);
        end else begin
            edge_node = (here[dim] == 0);
        end
        if (dir == noc_pkg::dir_eject) begin
            vc = r.vc_in;
        end else if (dir != r.port) begin
            vc = 1'b0;
        end else if (edge_node) begin
            vc = 1'b1;
        end else begin
            vc = r.vc_in;
        end
        return {vc, dir};
    endfunction

    // payload holds row and flit index
    function automatic noc_pkg::flit_t build_flit(input int row, input int idx);
        noc_pkg::flit_t f;
        row_t           r;
        r = pkt_table[row];
        if (r.nflits == 4'd1) begin
            f.ftype = noc_pkg::single_flit;
        end else if (idx == 0) begin
            f.ftype = noc_pkg::head_flit;
        end else if (idx == int'(r.nflits) - 1) begin
            f.ftype = noc_pkg::tail_flit;
        end else begin
            f.ftype = noc_pkg::body_flit;
        end
        if (idx == 0) begin
            f.vc_class = r.vc_in;
            f.dst_z    = r.dz;
            f.dst_y    = r.dy;
            f.dst_x    = r.dx;
        end else begin
            // body and tail carry the head's bits inverted
            f.vc_class = ~r.vc_in;
            f.dst_z    = ~r.dz;
            f.dst_y    = ~r.dy;
            f.dst_x    = ~r.dx;
        end
        f.cmp      = 4'(row) ^ 4'ha;
        f.payload  = {10'(row), 8'(idx)};
        return f;
    endfunction

    ////////////////////
    // output monitor
    ////////////////////
    task automatic record_output(input int side, input noc_pkg::flit_t f,
                                 input logic [2:0] dir);
        int             row;
        int             idx;
        row_t           r;
        noc_pkg::flit_t exp_f;
        logic           to_eject;
        row = int'(f.payload[17:8]);
        idx = int'(f.payload[7:0]);
        check_eq(32'(row < num_rows), 32'(1), "payload row out of range");
        r     = pkt_table[row];
        exp_f = build_flit(row, idx);
        if (idx == 0) begin
            exp_f.vc_class = r.exp_vc;
        end
        to_eject = (r.exp_dir == noc_pkg::dir_eject);
        check_eq(f, exp_f, "flit contents");
        check_eq(32'(side), 32'(to_eject), "output side");
        check_eq(32'(dir), 32'(r.exp_dir), "output direction");
        check_eq(32'(idx), 32'(rx_count[row]), "flit order within packet");
        if (idx == 0) begin
            check_eq(32'(open_row[side]), 32'(-1), "head inside another worm");
            if (r.nflits > 4'd1) begin
                open_row[side] = row;
            end
        end else begin
            check_eq(32'(open_row[side]), 32'(row), "packets interleaved");
            if (idx == int'(r.nflits) - 1) begin
                open_row[side] = -1;
            end
        end
        rx_count[row] = rx_count[row] + 1;
        rx_total      = rx_total + 1;
        if (row == 0 && idx == 0) begin
            out_cycle0 = cycle;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < num_rows; k++) begin
                rx_count[k] = 0;
            end
            open_row[0] = -1;
            open_row[1] = -1;
            rx_total    = 0;
            out_stall   = 1'b0;
            ej_stall    = 1'b0;
        end else begin
            // stalled outputs must hold
            if (out_stall) begin
                check_eq(32'(out_valid), 32'(1), "out_valid dropped while stalled");
                check_eq(out_flit, out_held, "out_flit changed while stalled");
                check_eq(32'(out_dir), 32'(dir_held), "out_dir changed while stalled");
            end
            if (ej_stall) begin
                check_eq(32'(ej_valid), 32'(1), "ej_valid dropped while stalled");
                check_eq(ej_flit, ej_held, "ej_flit changed while stalled");
            end
            if (out_valid && out_ready) begin
                record_output(0, out_flit, out_dir);
            end
            if (ej_valid && ej_ready) begin
                record_output(1, ej_flit, noc_pkg::dir_eject);
            end
            out_stall = out_valid && !out_ready;
            out_held  = out_flit;
            dir_held  = out_dir;
            ej_stall  = ej_valid && !ej_ready;
            ej_held   = ej_flit;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    always @(negedge clk) begin
        logic [31:0] r;
        if (random_ready) begin
            r         = $random(seed);
            out_ready = |r[1:0];
            ej_ready  = |r[3:2];
        end else begin
            out_ready = 1'b1;
            ej_ready  = 1'b1;
        end
    end

    task automatic send_packet(input int row);
        logic accepted;
        for (int idx = 0; idx < int'(pkt_table[row].nflits); idx++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_flit  = build_flit(row, idx);
            in_port  = pkt_table[row].port;
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                accepted = in_ready;
            end
            if (row == 0 && idx == 0) begin
                in_cycle0 = cycle;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    initial begin
        logic [3:0] model;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_flit  = '0;
        in_port  = '0;

        // table expectations against the model
        for (int row = 0; row < num_rows; row++) begin
            model = ref_route(pkt_table[row]);
            check_eq(32'(model[2:0]), 32'(pkt_table[row].exp_dir), "table direction");
            check_eq(32'(model[3]), 32'(pkt_table[row].exp_vc), "table class");
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // single flit on an idle router
        send_packet(0);
        while (rx_total < 1) begin
            @(negedge clk);
        end
        check_eq(32'(out_cycle0 - in_cycle0), 32'(3), "idle latency of a single flit");

        @(posedge clk);
        random_ready = 1'b1;
        for (int row = 1; row < num_rows; row++) begin
            send_packet(row);
        end
        while (rx_total < total_flits) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        for (int row = 0; row < num_rows; row++) begin
            check_eq(32'(rx_count[row]), 32'(pkt_table[row].nflits), "flits of packet");
        end
        check_eq(32'(open_row[0]), 32'(-1), "network worm left open");
        check_eq(32'(open_row[1]), 32'(-1), "eject worm left open");

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
